// File: files.f
+incdir+hw
hw/rv_core_pkg.sv
hw/rv_control.sv
hw/pc_counter.sv
hw/regfile.sv
hw/alu.sv
hw/load_store_unit.sv
hw/rv_core.sv
tests/tb_rv_core.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f files.f --top-module tb_rv_core -o tb_rv_core_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_rv_core_sim > sim.log 2>&1
sim_status=$?
cat sim.log

if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -q "^NO ERRORS$" sim.log; then
    echo "Test passed"
    exit 0
fi

echo "Test failed"
exit 1

// File: tests/tb_rv_core.sv
// Random program testbench for the core

`timescale 1ns/10ps

`include "rv_core_defines.svh"

module tb_rv_core;
    import rv_core_pkg::*;

    typedef enum int {
        K_ADD, K_SUB, K_AND, K_OR, K_XOR, K_SLT, K_SLL, K_SRL,
        K_ADDI, K_ANDI, K_ORI, K_XORI, K_LW, K_LB, K_LBU, K_SW, K_SB,
        K_BEQ, K_BNE, K_LUI, K_COUNT
    } kind_t;

    // Index of the final self-loop, after the no-op and 64 random instructions
    localparam int LAST = 65;
    localparam int TIMEOUT_CYCLES = 1000;

    logic        clk;
    logic        rst_n;
    logic [31:0] imem_addr;
    logic [31:0] imem_data;
    dmem_req_t   dmem_req;
    logic [31:0] dmem_rdata;
    wb_t         wb;

    integer      seed = 32'hfd8d5cb2;

    logic [31:0] imem [128];
    logic [31:0] dut_mem [64];
    logic [31:0] ref_mem [64];
    kind_t       kind_a [LAST];
    logic [31:0] rd_a [LAST];
    logic [31:0] rs1_a [LAST];
    logic [31:0] rs2_a [LAST];
    logic [31:0] imm_a [LAST];
    logic [31:0] xr [8];

    // Expected event streams from the ISA model
    wb_t         wb_q [$];
    dmem_req_t   st_q [$];
    logic [31:0] ld_q [$];
    logic [31:0] pc_q [$];
    int          cyc_q [$];

    dmem_req_t   req_s;
    logic        re_prev;
    logic        pc_seen;
    logic [31:0] cur_pc;
    int          cur_cycles;
    int          cycles_exp;

    rv_core u_rv_core (
        .clk          (clk),
        .rst_n        (rst_n),
        .o_imem_addr  (imem_addr),
        .i_imem_data  (imem_data),
        .o_dmem       (dmem_req),
        .i_dmem_rdata (dmem_rdata),
        .o_wb         (wb)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic stop_with_error(input string msg);
        $display("%s", msg);
        $display("ERRORS FOUND");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            stop_with_error($sformatf("Mismatch at %0t: %s is %h, expected %h",
                                      $time, what, actual, expected));
        end
    endtask

    function automatic int rnd(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    function automatic logic [31:0] encode(input kind_t k, input logic [4:0] rd,
                                           input logic [4:0] rs1, input logic [4:0] rs2,
                                           input logic [31:0] imm);
        logic [2:0] f3;
        logic [6:0] f7;
        f7 = (k == K_SUB) ? 7'b0100000 : 7'b0000000;
        case (k)
            K_ADD, K_SUB, K_ADDI, K_LB, K_SB, K_BEQ: f3 = 3'b000;
            K_AND, K_ANDI:                           f3 = 3'b111;
            K_OR, K_ORI:                             f3 = 3'b110;
            K_XOR, K_XORI, K_LBU:                    f3 = 3'b100;
            K_SLT, K_LW, K_SW:                       f3 = 3'b010;
            K_SLL, K_BNE:                            f3 = 3'b001;
            default:                                 f3 = 3'b101;
        endcase
        case (k)
            K_ADDI, K_ANDI, K_ORI, K_XORI: return {imm[11:0], rs1, f3, rd, 7'b0010011};
            K_LW, K_LB, K_LBU:             return {imm[11:0], rs1, f3, rd, 7'b0000011};
            K_SW, K_SB:    return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
            K_BEQ, K_BNE:  return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11],
                                   7'b1100011};
            K_LUI:         return {imm[31:12], rd, 7'b0110111};
            default:       return {f7, rs2, rs1, f3, rd, 7'b0110011};
        endcase
    endfunction

    task automatic build_program();
        int target;
        for (int a = 0; a < 128; a++) begin
            imem[a] = 32'h0000_0013;
        end
        for (int a = 0; a < 64; a++) begin
            dut_mem[a] = (a + 1) * 32'h9e37_79b9;
            ref_mem[a] = dut_mem[a];
        end
        for (int i = 0; i < LAST; i++) begin
            if (i == 0) begin
                // Plain no-op first, so reset shows no strobes
                kind_a[i] = K_ADDI;
                rd_a[i]   = 0;
                rs1_a[i]  = 0;
                rs2_a[i]  = 0;
                imm_a[i]  = 0;
            end else begin
                kind_a[i] = kind_t'(rnd(K_COUNT));
                rd_a[i]   = rnd(8);
                rs1_a[i]  = rnd(8);
                rs2_a[i]  = rnd(8);
                case (kind_a[i])
                    K_LW, K_SW:        imm_a[i] = rnd(64) * 4;
                    K_LB, K_LBU, K_SB: imm_a[i] = rnd(256);
                    K_BEQ, K_BNE: begin
                        target = i + 1 + rnd(4);
                        if (target > LAST) begin
                            target = LAST;
                        end
                        imm_a[i] = (target - i) * 4;
                    end
                    K_LUI:   imm_a[i] = $random(seed) & 32'hffff_f000;
                    default: imm_a[i] = rnd(4096) - 2048;
                endcase
                // x0 base keeps every access inside the data array
                if (kind_a[i] inside {K_LW, K_LB, K_LBU, K_SW, K_SB}) begin
                    rs1_a[i] = 0;
                end
            end
            imem[i] = encode(kind_a[i], rd_a[i][4:0], rs1_a[i][4:0], rs2_a[i][4:0], imm_a[i]);
        end
        imem[LAST] = encode(K_BEQ, 5'd0, 5'd0, 5'd0, 32'd0);
    endtask

    task automatic run_model();
        int          pc_i;
        int          next_i;
        kind_t       k;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm;
        logic [31:0] res;
        logic [31:0] word;
        logic [7:0]  lane;
        logic        wr;
        wb_t         e_wb;
        dmem_req_t   e_st;
        for (int r = 0; r < 8; r++) begin
            xr[r] = 0;
        end
        pc_i = 0;
        while (pc_i != LAST) begin
            k      = kind_a[pc_i];
            a      = xr[rs1_a[pc_i][2:0]];
            b      = xr[rs2_a[pc_i][2:0]];
            imm    = imm_a[pc_i];
            res    = 0;
            wr     = 1'b1;
            next_i = pc_i + 1;
            pc_q.push_back(pc_i * 4);
            cyc_q.push_back((k inside {K_LW, K_LB, K_LBU}) ? 2 : 1);
            case (k)
                K_ADD:  res = a + b;
                K_SUB:  res = a - b;
                K_AND:  res = a & b;
                K_OR:   res = a | b;
                K_XOR:  res = a ^ b;
                K_SLT:  res = ($signed(a) < $signed(b)) ? 1 : 0;
                K_SLL:  res = a << b[4:0];
                K_SRL:  res = a >> b[4:0];
                K_ADDI: res = a + imm;
                K_ANDI: res = a & imm;
                K_ORI:  res = a | imm;
                K_XORI: res = a ^ imm;
                K_LUI:  res = imm;
                K_LW, K_LB, K_LBU: begin
                    ld_q.push_back({imm[31:2], 2'b00});
                    word = ref_mem[imm[7:2]];
                    lane = word[8*imm[1:0] +: 8];
                    if (k == K_LW) begin
                        res = word;
                    end else if (k == K_LB) begin
                        res = {{24{lane[7]}}, lane};
                    end else begin
                        res = {24'b0, lane};
                    end
                end
                K_SW, K_SB: begin
                    wr        = 1'b0;
                    e_st      = '0;
                    e_st.we   = 1'b1;
                    e_st.addr = {imm[31:2], 2'b00};
                    if (k == K_SW) begin
                        e_st.be    = 4'b1111;
                        e_st.wdata = b;
                        ref_mem[imm[7:2]] = b;
                    end else begin
                        e_st.be    = 4'b0001 << imm[1:0];
                        e_st.wdata = {4{b[7:0]}};
                        ref_mem[imm[7:2]][8*imm[1:0] +: 8] = b[7:0];
                    end
                    st_q.push_back(e_st);
                end
                default: begin
                    wr = 1'b0;
                    if ((a == b) == (k == K_BEQ)) begin
                        next_i = pc_i + int'(imm >> 2);
                    end
                end
            endcase
            if (wr && rd_a[pc_i] != 0) begin
                e_wb.valid = 1'b1;
                e_wb.rd    = rd_a[pc_i][4:0];
                e_wb.data  = res;
                wb_q.push_back(e_wb);
                xr[rd_a[pc_i][2:0]] = res;
            end
            pc_i = next_i;
        end
        pc_q.push_back(LAST * 4);
        cyc_q.push_back(1);
    endtask

    task automatic track_pc();
        if (pc_seen && imem_addr == cur_pc) begin
            cur_cycles++;
        end else if (pc_q.size() == 0) begin
            stop_with_error("Fetch address moved on past the final loop");
        end else begin
            if (pc_seen) begin
                check_value(cur_cycles, cycles_exp, $sformatf("cycles at PC %h", cur_pc));
            end
            check_value(imem_addr, pc_q[0], "fetch address");
            cycles_exp = cyc_q.pop_front();
            void'(pc_q.pop_front());
            cur_pc     = imem_addr;
            cur_cycles = 1;
            pc_seen    = 1'b1;
        end
    endtask

    // Memory models act just after the rising edge on requests seen at the falling edge
    always @(posedge clk) begin
        #1;
        if (req_s.we) begin
            for (int l = 0; l < 4; l++) begin
                if (req_s.be[l]) begin
                    dut_mem[req_s.addr[7:2]][8*l +: 8] = req_s.wdata[8*l +: 8];
                end
            end
        end
        if (req_s.re) begin
            dmem_rdata = dut_mem[req_s.addr[7:2]];
        end
        imem_data = imem[imem_addr[8:2]];
    end

    // Outputs are settled at the falling edge
    always @(negedge clk) begin
        if (rst_n) begin
            track_pc();
            if (wb.valid) begin
                if (wb.rd == 5'd0) begin
                    stop_with_error("A write-back to x0 appeared on o_wb");
                end else if (wb_q.size() == 0) begin
                    stop_with_error("A write-back appeared after all expected ones were seen");
                end else begin
                    check_value({27'b0, wb.rd}, {27'b0, wb_q[0].rd}, "write-back rd");
                    check_value(wb.data, wb_q[0].data, "write-back data");
                    void'(wb_q.pop_front());
                end
            end
            if (dmem_req.we) begin
                if (st_q.size() == 0) begin
                    stop_with_error("A store strobe appeared after all expected stores");
                end else begin
                    check_value(dmem_req.addr, st_q[0].addr, "store address");
                    check_value({28'b0, dmem_req.be}, {28'b0, st_q[0].be}, "store byte enables");
                    check_value(dmem_req.wdata, st_q[0].wdata, "store data");
                    void'(st_q.pop_front());
                end
            end
            if (dmem_req.re) begin
                if (re_prev) begin
                    stop_with_error("The read strobe stayed high for a second cycle");
                end else if (ld_q.size() == 0) begin
                    stop_with_error("A read strobe appeared after all expected loads");
                end else begin
                    check_value(dmem_req.addr, ld_q[0], "load address");
                    void'(ld_q.pop_front());
                end
            end
            re_prev = dmem_req.re;
        end
        req_s = dmem_req;
    end

    initial begin
        int cycles;
        rst_n      = 1'b0;
        imem_data  = 32'h0000_0013;
        dmem_rdata = 32'h0;
        req_s      = '0;
        re_prev    = 1'b0;
        pc_seen    = 1'b0;
        cur_pc     = 32'h0;
        cur_cycles = 0;
        cycles_exp = 0;
        build_program();
        run_model();

        @(posedge clk);
        @(negedge clk);
        check_value(imem_addr, `RV_RESET_PC, "fetch address in reset");
        check_value({31'b0, wb.valid}, 32'd0, "write-back valid in reset");
        check_value({31'b0, dmem_req.we}, 32'd0, "store strobe in reset");
        check_value({31'b0, dmem_req.re}, 32'd0, "read strobe in reset");
        @(posedge clk);
        #1;
        rst_n = 1'b1;

        cycles = 0;
        while (pc_q.size() != 0 || wb_q.size() != 0 || st_q.size() != 0 || ld_q.size() != 0) begin
            @(posedge clk);
            cycles++;
            if (cycles > TIMEOUT_CYCLES) begin
                stop_with_error("Timeout: the program never reached the final loop with all results");
            end
        end

        // Spin on the final loop, nothing else may come out
        repeat (10) @(posedge clk);
        check_value(imem_addr, LAST * 4, "final fetch address");
        $display("NO ERRORS");
        $finish;
    end

endmodule

// File: hw/rv_core.sv
// Single-cycle RV32I subset core

`timescale 1ns/10ps

`include "rv_core_defines.svh"

module rv_core (
    input  logic                   clk,
    input  logic                   rst_n,
    output logic [`RV_XLEN-1:0]    o_imem_addr,
    input  logic [`RV_XLEN-1:0]    i_imem_data,
    output rv_core_pkg::dmem_req_t o_dmem,
    input  logic [`RV_XLEN-1:0]    i_dmem_rdata,
    output rv_core_pkg::wb_t       o_wb
);
    import rv_core_pkg::*;

    instr_t              instr;
    ctrl_t               ctrl;
    logic                pc_hold;
    logic                load_done;
    logic                branch_taken;
    logic                alu_zero;
    logic [`RV_XLEN-1:0] rs1_data;
    logic [`RV_XLEN-1:0] rs2_data;
    logic [`RV_XLEN-1:0] alu_b;
    logic [`RV_XLEN-1:0] alu_result;
    logic [`RV_XLEN-1:0] lsu_addr;
    logic [`RV_XLEN-1:0] load_data;
    logic [1:0]          load_offset_q;
    mem_size_t           load_size_q;
    mem_size_t           lsu_size;

    assign instr = i_imem_data;

    rv_control u_control (
        .clk         (clk),
        .rst_n       (rst_n),
        .i_instr     (instr),
        .o_ctrl      (ctrl),
        .o_pc_hold   (pc_hold),
        .o_load_done (load_done)
    );

    assign branch_taken = ctrl.is_branch && (alu_zero == ctrl.branch_on_equal);

    pc_counter u_pc (
        .clk            (clk),
        .rst_n          (rst_n),
        .i_hold         (pc_hold),
        .i_branch_taken (branch_taken),
        .i_offset       (ctrl.immediate),
        .o_pc           (o_imem_addr)
    );

    regfile u_regfile (
        .clk        (clk),
        .rst_n      (rst_n),
        .i_rs1      (instr.r_fmt.rs1),
        .i_rs2      (instr.r_fmt.rs2),
        .i_wb       (o_wb),
        .o_rs1_data (rs1_data),
        .o_rs2_data (rs2_data)
    );

    assign alu_b = ctrl.alu_src_imm ? ctrl.immediate : rs2_data;

    alu u_alu (
        .i_op     (ctrl.alu_op),
        .i_a      (rs1_data),
        .i_b      (alu_b),
        .o_result (alu_result),
        .o_zero   (alu_zero)
    );

    // Byte offset and size captured when the read is issued
    always_ff @(posedge clk) begin
        if (ctrl.mem_read) begin
            load_offset_q <= alu_result[1:0];
            load_size_q   <= ctrl.mem_size;
        end
    end

    // No store can happen in LOAD_WAIT, so the return path owns the LSU then
    assign lsu_addr = {alu_result[`RV_XLEN-1:2], load_done ? load_offset_q : alu_result[1:0]};
    assign lsu_size = load_done ? load_size_q : ctrl.mem_size;

    load_store_unit u_lsu (
        .i_addr       (lsu_addr),
        .i_store_data (rs2_data),
        .i_size       (lsu_size),
        .i_rdata      (i_dmem_rdata),
        .o_be         (o_dmem.be),
        .o_wdata      (o_dmem.wdata),
        .o_load_data  (load_data)
    );

    assign o_dmem.re   = ctrl.mem_read;
    assign o_dmem.we   = ctrl.mem_write;
    assign o_dmem.addr = {alu_result[`RV_XLEN-1:2], 2'b00};

    // Writes to x0 never leave the core
    assign o_wb.valid = ctrl.reg_write && (instr.r_fmt.rd != 5'd0);
    assign o_wb.rd    = instr.r_fmt.rd;
    assign o_wb.data  = load_done ? load_data : alu_result;

endmodule

// File: hw/load_store_unit.sv
// Load and store byte lane handling

`timescale 1ns/10ps

`include "rv_core_defines.svh"

module load_store_unit (
    input  logic [`RV_XLEN-1:0]    i_addr,
    input  logic [`RV_XLEN-1:0]    i_store_data,
    input  rv_core_pkg::mem_size_t i_size,
    input  logic [`RV_XLEN-1:0]    i_rdata,
    output logic [3:0]             o_be,
    output logic [`RV_XLEN-1:0]    o_wdata,
    output logic [`RV_XLEN-1:0]    o_load_data
);
    import rv_core_pkg::*;

    logic [1:0] offset;
    logic [7:0] rd_byte;

    assign offset = i_addr[1:0];

    // Store side
    always_comb begin
        if (i_size == SIZE_WORD) begin
            o_be    = 4'b1111;
            o_wdata = i_store_data;
        end else begin
            o_be    = 4'b0001 << offset;
            o_wdata = {4{i_store_data[7:0]}};
        end
    end

    // Load side, offset and size come from the issue cycle
    assign rd_byte = i_rdata[8*offset +: 8];

    always_comb begin
        case (i_size)
            SIZE_BYTE_S: o_load_data = {{24{rd_byte[7]}}, rd_byte};
            SIZE_BYTE_U: o_load_data = {24'b0, rd_byte};
            default:     o_load_data = i_rdata;
        endcase
    end

endmodule

// File: hw/alu.sv
// Integer ALU

`timescale 1ns/10ps

`include "rv_core_defines.svh"

module alu (
    input  rv_core_pkg::alu_op_t i_op,
    input  logic [`RV_XLEN-1:0]  i_a,
    input  logic [`RV_XLEN-1:0]  i_b,
    output logic [`RV_XLEN-1:0]  o_result,
    output logic                 o_zero
);
    import rv_core_pkg::*;

    logic [4:0] shamt;

    assign shamt = i_b[4:0];

    always_comb begin
        case (i_op)
            ALU_ADD:    o_result = i_a + i_b;
            ALU_SUB:    o_result = i_a - i_b;
            ALU_AND:    o_result = i_a & i_b;
            ALU_OR:     o_result = i_a | i_b;
            ALU_XOR:    o_result = i_a ^ i_b;
            // Signed compare, result is 0 or 1
            ALU_SLT:    o_result = {{(`RV_XLEN-1){1'b0}}, $signed(i_a) < $signed(i_b)};
            ALU_SLL:    o_result = i_a << shamt;
            ALU_SRL:    o_result = i_a >> shamt;
            ALU_PASS_B: o_result = i_b;
            default:    o_result = '0;
        endcase
    end

    // Used for BEQ and BNE after a subtract
    assign o_zero = (o_result == '0);

endmodule

// File: hw/regfile.sv
// Integer register file

`timescale 1ns/10ps

`include "rv_core_defines.svh"

module regfile (
    input  logic                clk,
    input  logic                rst_n,
    input  logic [4:0]          i_rs1,
    input  logic [4:0]          i_rs2,
    input  rv_core_pkg::wb_t    i_wb,
    output logic [`RV_XLEN-1:0] o_rs1_data,
    output logic [`RV_XLEN-1:0] o_rs2_data
);

    logic [`RV_XLEN-1:0] regs [`RV_REG_COUNT];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `RV_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (i_wb.valid) begin
            regs[i_wb.rd] <= i_wb.data;
        end
    end

    // x0 is hardwired to zero
    assign o_rs1_data = (i_rs1 == 5'd0) ? '0 : regs[i_rs1];
    assign o_rs2_data = (i_rs2 == 5'd0) ? '0 : regs[i_rs2];

endmodule

// File: hw/pc_counter.sv
// Program counter

`timescale 1ns/10ps

`include "rv_core_defines.svh"

module pc_counter (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                i_hold,
    input  logic                i_branch_taken,
    input  logic [`RV_XLEN-1:0] i_offset,
    output logic [`RV_XLEN-1:0] o_pc
);

    logic [`RV_XLEN-1:0] pc_next;

    // Hold wins, it only comes with a load
    always_comb begin
        if (i_hold) begin
            pc_next = o_pc;
        end else if (i_branch_taken) begin
            pc_next = o_pc + i_offset;
        end else begin
            pc_next = o_pc + `RV_XLEN'd4;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            o_pc <= `RV_RESET_PC;
        end else begin
            o_pc <= pc_next;
        end
    end

endmodule

// File: hw/rv_control.sv
// Instruction decoder and load sequencing

`timescale 1ns/10ps

module rv_control (
    input  logic                clk,
    input  logic                rst_n,
    input  rv_core_pkg::instr_t i_instr,
    output rv_core_pkg::ctrl_t  o_ctrl,
    output logic                o_pc_hold,
    output logic                o_load_done
);
    import rv_core_pkg::*;

    typedef enum logic {EXECUTE, LOAD_WAIT} state_t;

    state_t      state;
    ctrl_t       dec;
    logic        load_issue;
    logic [31:0] imm_i;
    logic [31:0] imm_s;
    logic [31:0] imm_b;
    logic [31:0] imm_u;

    assign imm_i = {{20{i_instr.i_fmt.imm[11]}}, i_instr.i_fmt.imm};
    assign imm_s = {{20{i_instr.s_fmt.imm_hi[6]}}, i_instr.s_fmt.imm_hi, i_instr.s_fmt.imm_lo};
    // B-type bits are scattered over the S-type fields
    assign imm_b = {{19{i_instr.s_fmt.imm_hi[6]}}, i_instr.s_fmt.imm_hi[6],
                    i_instr.s_fmt.imm_lo[0], i_instr.s_fmt.imm_hi[5:0],
                    i_instr.s_fmt.imm_lo[4:1], 1'b0};
    assign imm_u = {i_instr.i_fmt.imm, i_instr.i_fmt.rs1, i_instr.i_fmt.funct3, 12'b0};

    always_comb begin
        dec          = '0;
        dec.alu_op   = ALU_ADD;
        dec.mem_size = SIZE_WORD;
        case (i_instr.r_fmt.opcode)
            OP_REG: begin
                dec.reg_write = 1'b1;
                case (i_instr.r_fmt.funct3)
                    3'b000:  dec.alu_op = i_instr.r_fmt.funct7[5] ? ALU_SUB : ALU_ADD;
                    3'b111:  dec.alu_op = ALU_AND;
                    3'b110:  dec.alu_op = ALU_OR;
                    3'b100:  dec.alu_op = ALU_XOR;
                    3'b010:  dec.alu_op = ALU_SLT;
                    3'b001:  dec.alu_op = ALU_SLL;
                    3'b101:  dec.alu_op = ALU_SRL;
                    default: dec.reg_write = 1'b0;
                endcase
            end
            OP_IMM: begin
                dec.alu_src_imm = 1'b1;
                dec.reg_write   = 1'b1;
                dec.immediate   = imm_i;
                case (i_instr.i_fmt.funct3)
                    3'b000:  dec.alu_op = ALU_ADD;
                    3'b111:  dec.alu_op = ALU_AND;
                    3'b110:  dec.alu_op = ALU_OR;
                    3'b100:  dec.alu_op = ALU_XOR;
                    default: dec.reg_write = 1'b0;
                endcase
            end
            OP_LOAD: begin
                dec.alu_src_imm = 1'b1;
                dec.immediate   = imm_i;
                dec.mem_read    = 1'b1;
                case (i_instr.i_fmt.funct3)
                    3'b010:  dec.mem_size = SIZE_WORD;
                    3'b000:  dec.mem_size = SIZE_BYTE_S;
                    3'b100:  dec.mem_size = SIZE_BYTE_U;
                    default: dec.mem_read = 1'b0;
                endcase
            end
            OP_STORE: begin
                dec.alu_src_imm = 1'b1;
                dec.immediate   = imm_s;
                dec.mem_write   = 1'b1;
                case (i_instr.s_fmt.funct3)
                    3'b010:  dec.mem_size = SIZE_WORD;
                    3'b000:  dec.mem_size = SIZE_BYTE_U;
                    default: dec.mem_write = 1'b0;
                endcase
            end
            OP_BRANCH: begin
                // Compare by subtraction, decide on the zero flag
                dec.alu_op    = ALU_SUB;
                dec.immediate = imm_b;
                dec.is_branch = 1'b1;
                case (i_instr.s_fmt.funct3)
                    3'b000:  dec.branch_on_equal = 1'b1;
                    3'b001:  dec.branch_on_equal = 1'b0;
                    default: dec.is_branch = 1'b0;
                endcase
            end
            OP_LUI: begin
                dec.alu_op      = ALU_PASS_B;
                dec.alu_src_imm = 1'b1;
                dec.reg_write   = 1'b1;
                dec.immediate   = imm_u;
            end
            default: ;
        endcase
    end

    // First cycle of a load issues the read and stalls the PC
    assign load_issue  = dec.mem_read && (state == EXECUTE);
    assign o_pc_hold   = load_issue;
    assign o_load_done = (state == LOAD_WAIT);

    always_comb begin
        o_ctrl           = dec;
        o_ctrl.mem_read  = load_issue;
        o_ctrl.reg_write = dec.reg_write | (dec.mem_read & o_load_done);
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= EXECUTE;
        end else if (load_issue) begin
            state <= LOAD_WAIT;
        end else begin
            state <= EXECUTE;
        end
    end

endmodule

// File: hw/rv_core_pkg.sv
// Core shared types

`include "rv_core_defines.svh"

package rv_core_pkg;

    typedef enum logic [6:0] {
        OP_REG    = 7'b0110011,
        OP_IMM    = 7'b0010011,
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_BRANCH = 7'b1100011,
        OP_LUI    = 7'b0110111
    } opcode_t;

    typedef enum logic [3:0] {
        ALU_ADD    = 4'd0,
        ALU_SUB    = 4'd1,
        ALU_AND    = 4'd2,
        ALU_OR     = 4'd3,
        ALU_XOR    = 4'd4,
        ALU_SLT    = 4'd5,
        ALU_SLL    = 4'd6,
        ALU_SRL    = 4'd7,
        ALU_PASS_B = 4'd8
    } alu_op_t;

    typedef enum logic [1:0] {
        SIZE_BYTE_S = 2'd0,
        SIZE_BYTE_U = 2'd1,
        SIZE_WORD   = 2'd2
    } mem_size_t;

    // One instruction word, three field layouts
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            opcode_t    opcode;
        } r_fmt;
        struct packed {
            logic [11:0] imm;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            opcode_t     opcode;
        } i_fmt;
        // Also carries the B-type immediate bits
        struct packed {
            logic [6:0] imm_hi;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] imm_lo;
            opcode_t    opcode;
        } s_fmt;
    } instr_t;

    typedef struct packed {
        alu_op_t               alu_op;
        logic                  alu_src_imm;
        logic                  reg_write;
        logic                  mem_read;
        logic                  mem_write;
        mem_size_t             mem_size;
        logic                  is_branch;
        logic                  branch_on_equal;
        logic [`RV_XLEN-1:0]   immediate;
    } ctrl_t;

    typedef struct packed {
        logic                valid;
        logic [4:0]          rd;
        logic [`RV_XLEN-1:0] data;
    } wb_t;

    typedef struct packed {
        logic                re;
        logic                we;
        logic [`RV_XLEN-1:0] addr;
        logic [`RV_XLEN-1:0] wdata;
        logic [3:0]          be;
    } dmem_req_t;

endpackage

// File: hw/rv_core_defines.svh
// Core size defines

`ifndef RV_CORE_DEFINES_SVH
`define RV_CORE_DEFINES_SVH

// Data and address width
`define RV_XLEN 32

// Architectural registers, x0 included
`define RV_REG_COUNT 32

// First fetch address after reset
`define RV_RESET_PC 32'h0000_0000

`endif
